// File: common/nes_glue_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, enums and packed structs of the NES glue layer.
// Every block refers to these by scoped name.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package nes_glue_pkg;

  localparam int ADDR_W = 22;  // 4 MB memory space
  localparam int BTN_W  = 8;

  // host link register map
  typedef enum logic [7:0] {
    REG_LOADER_CONF = 8'h35,
    REG_LOADER_DATA = 8'h37,
    REG_BTN_P1      = 8'h40,
    REG_BTN_P2      = 8'h41
  } host_reg_e;

  // five-cycle memory / console slot
  typedef enum logic [2:0] {
    PH_MEM  = 3'd0,  // command issued to memory
    PH_ACT  = 3'd1,
    PH_RW   = 3'd2,
    PH_WAIT = 3'd3,
    PH_NES  = 3'd4   // console core steps
  } nes_phase_e;

  typedef struct packed {
    logic       valid;
    logic [7:0] addr;
    logic [7:0] data;
  } host_wr_t;

  // NES shift order, a goes out first
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic start;
    logic select;
    logic b;
    logic a;
  } nes_btn_t;

  // active low button bytes from the Dualshock receiver
  typedef struct packed {
    logic [7:0] rx0;  // select L3 R3 start up right down left, from bit 0
    logic [7:0] rx1;  // L2 R2 L1 R1 triangle circle cross square, from bit 0
  } ds2_rx_t;

  typedef struct packed {
    logic              read_cpu;
    logic              read_ppu;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        data;
  } nes_mem_req_t;

  typedef struct packed {
    logic              write;
    logic              refresh;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        data;
  } loader_wr_t;

  typedef struct packed {
    logic              read_a;
    logic              read_b;
    logic              write;
    logic              refresh;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        data;
  } mem_cmd_t;

endpackage

// File: source/host_reg_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host register decode. Byte writes from the serial host link land in the
// loader config and host button registers; writes at the loader data address
// come out as a one-cycle ROM byte strobe.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module host_reg_decode (
  input  logic                           clk,
  input  logic                           sys_resetn,
  input  nes_glue_pkg::host_wr_t         i_host_wr,
  output logic [7:0]                     o_loader_byte,
  output logic                           o_loader_byte_valid,
  output logic                           o_loader_reset,
  output nes_glue_pkg::nes_btn_t [1:0]   o_host_btn
);

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      o_loader_byte       <= '0;
      o_loader_byte_valid <= 1'b0;
      o_loader_reset      <= 1'b0;
      o_host_btn          <= '0;
    end else begin
      o_loader_byte_valid <= 1'b0;  // strobe, one cycle only
      if (i_host_wr.valid) begin
        case (i_host_wr.addr)
          nes_glue_pkg::REG_LOADER_CONF: begin
            o_loader_reset <= i_host_wr.data[0];  // conf bit 0 holds loader in reset
          end
          nes_glue_pkg::REG_LOADER_DATA: begin
            o_loader_byte       <= i_host_wr.data;
            o_loader_byte_valid <= 1'b1;
          end
          nes_glue_pkg::REG_BTN_P1: o_host_btn[0] <= i_host_wr.data;
          nes_glue_pkg::REG_BTN_P2: o_host_btn[1] <= i_host_wr.data;
          default: begin
            // other addresses belong to other listeners
          end
        endcase
      end
    end
  end

endmodule

// File: source/pad_merge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Controller merge. Maps both Dualshock pads to NES button bytes, adds
// autofire on square (b) and triangle (a), and ORs in the aux and host bytes.
// Output is registered, one cycle behind the inputs.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pad_merge #(
  parameter int AUTOFIRE_PERIOD = 600000
) (
  input  logic                           clk,
  input  logic                           sys_resetn,
  input  nes_glue_pkg::ds2_rx_t [1:0]    i_ds2,
  input  nes_glue_pkg::nes_btn_t [1:0]   i_aux_btn,
  input  nes_glue_pkg::nes_btn_t [1:0]   i_host_btn,
  output nes_glue_pkg::nes_btn_t [1:0]   o_pad_btn
);

  localparam int CNT_W = $clog2(AUTOFIRE_PERIOD + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(AUTOFIRE_PERIOD - 1);

  // index [player][k], k=0 square, k=1 triangle
  logic [1:0][1:0][CNT_W-1:0] af_cnt;
  logic [1:0][1:0]            af_out;
  logic [1:0][1:0]            af_held;

  // dualshock is active low, NES is active high
  function automatic nes_glue_pkg::nes_btn_t map_ds2(
    input nes_glue_pkg::ds2_rx_t rx,
    input logic                  af_b,
    input logic                  af_a
  );
    nes_glue_pkg::nes_btn_t btn;
    btn.right  = ~rx.rx0[5];
    btn.left   = ~rx.rx0[7];
    btn.down   = ~rx.rx0[6];
    btn.up     = ~rx.rx0[4];
    btn.start  = ~rx.rx0[3];
    btn.select = ~rx.rx0[0];
    btn.b      = ~rx.rx1[6] | af_b;  // cross
    btn.a      = ~rx.rx1[5] | af_a;  // circle
    return btn;
  endfunction

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      af_held[p][0] = ~i_ds2[p].rx1[7];  // square
      af_held[p][1] = ~i_ds2[p].rx1[4];  // triangle
    end
  end

  // toggle every AUTOFIRE_PERIOD cycles while held
  always_ff @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
      for (int k = 0; k < 2; k++) begin
        if (!sys_resetn || !af_held[p][k]) begin
          af_cnt[p][k] <= '0;
          af_out[p][k] <= 1'b0;
        end else if (af_cnt[p][k] == CNT_LAST) begin
          af_cnt[p][k] <= '0;
          af_out[p][k] <= ~af_out[p][k];
        end else begin
          af_cnt[p][k] <= af_cnt[p][k] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      o_pad_btn <= '0;
    end else begin
      for (int p = 0; p < 2; p++) begin
        o_pad_btn[p] <= map_ds2(i_ds2[p], af_out[p][0], af_out[p][1])
                        | i_aux_btn[p] | i_host_btn[p];
      end
    end
  end

endmodule

// File: source/joypad_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NES joypad ports. Strobe latches the button bytes, each falling edge of a
// port clock shifts that port right by one, so the core reads a bit per clock.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module joypad_port (
  input  logic                           clk,
  input  logic                           sys_resetn,
  input  nes_glue_pkg::nes_btn_t [1:0]   i_pad_btn,
  input  logic                           i_joy_strobe,
  input  logic [1:0]                     i_joy_clk,
  output logic [1:0]                     o_joy_data
);

  logic [1:0][nes_glue_pkg::BTN_W-1:0] joy_bits;
  logic [1:0]                          joy_clk_q;  // last clock sample per port

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      joy_bits  <= '0;
      joy_clk_q <= '0;
    end else begin
      joy_clk_q <= i_joy_clk;
      for (int p = 0; p < 2; p++) begin
        if (i_joy_strobe) begin
          joy_bits[p] <= i_pad_btn[p];
        end
        // later assignment, so a shift beats the strobe
        if (joy_clk_q[p] && !i_joy_clk[p]) begin
          joy_bits[p] <= {1'b0, joy_bits[p][nes_glue_pkg::BTN_W-1:1]};
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      o_joy_data[p] = joy_bits[p][0];
    end
  end

endmodule

// File: mem/mem_scheduler.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory scheduler. A five-phase sequencer gives the memory its slot on
// PH_MEM and the console its step on PH_NES, four cycles later. NES requests
// and loader writes merge into one command, with refresh in idle slots.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mem_scheduler (
  input  logic                        clk,
  input  logic                        sys_resetn,
  input  logic                        i_loader_done,
  input  nes_glue_pkg::nes_mem_req_t  i_nes_req,
  input  nes_glue_pkg::loader_wr_t    i_loader_wr,
  output logic                        o_run_mem,
  output logic                        o_run_nes,
  output nes_glue_pkg::mem_cmd_t      o_mem_cmd
);

  nes_glue_pkg::nes_phase_e phase;
  nes_glue_pkg::nes_phase_e phase_next;
  logic                     nes_busy;

  always_comb begin
    case (phase)
      nes_glue_pkg::PH_MEM:  phase_next = nes_glue_pkg::PH_ACT;
      nes_glue_pkg::PH_ACT:  phase_next = nes_glue_pkg::PH_RW;
      nes_glue_pkg::PH_RW:   phase_next = nes_glue_pkg::PH_WAIT;
      nes_glue_pkg::PH_WAIT: phase_next = nes_glue_pkg::PH_NES;
      default:               phase_next = nes_glue_pkg::PH_MEM;  // wrap after PH_NES
    endcase
  end

  // free running, the loader only gates the run strobes
  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      phase <= nes_glue_pkg::PH_MEM;
    end else begin
      phase <= phase_next;
    end
  end

  assign o_run_mem = (phase == nes_glue_pkg::PH_MEM) && i_loader_done;
  assign o_run_nes = (phase == nes_glue_pkg::PH_NES) && i_loader_done;

  assign nes_busy = i_nes_req.read_cpu | i_nes_req.read_ppu | i_nes_req.write;

  always_comb begin
    o_mem_cmd = '0;
    if (i_loader_wr.write) begin
      // loader owns the bus whenever it writes
      o_mem_cmd.write = 1'b1;
      o_mem_cmd.addr  = i_loader_wr.addr;
      o_mem_cmd.data  = i_loader_wr.data;
    end else begin
      o_mem_cmd.read_a  = i_nes_req.read_cpu & o_run_mem;
      o_mem_cmd.read_b  = i_nes_req.read_ppu & o_run_mem;
      o_mem_cmd.write   = i_nes_req.write & o_run_mem;
      o_mem_cmd.refresh = (o_run_mem & ~nes_busy)  // idle slot
                          | i_loader_wr.refresh;
      o_mem_cmd.addr    = i_nes_req.addr;
      o_mem_cmd.data    = i_nes_req.data;
    end
  end

endmodule

// File: source/nes_glue_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top of the NES glue layer. The button path runs host decode, controller
// merge and joypad ports in a row; the memory scheduler sits beside it.
// AUTOFIRE_PERIOD sets the autofire toggle time in clk cycles.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module nes_glue_top #(
  parameter int AUTOFIRE_PERIOD = 600000
) (
  input  logic                           clk,
  input  logic                           sys_resetn,
  // host link
  input  nes_glue_pkg::host_wr_t         i_host_wr,
  output logic [7:0]                     o_loader_byte,
  output logic                           o_loader_byte_valid,
  output logic                           o_loader_reset,
  // controllers and joypad ports
  input  nes_glue_pkg::ds2_rx_t [1:0]    i_ds2,
  input  nes_glue_pkg::nes_btn_t [1:0]   i_aux_btn,
  input  logic                           i_joy_strobe,
  input  logic [1:0]                     i_joy_clk,
  output logic [1:0]                     o_joy_data,
  // memory
  input  logic                           i_loader_done,
  input  nes_glue_pkg::nes_mem_req_t     i_nes_req,
  input  nes_glue_pkg::loader_wr_t       i_loader_wr,
  output logic                           o_run_mem,
  output logic                           o_run_nes,
  output nes_glue_pkg::mem_cmd_t         o_mem_cmd
);

  nes_glue_pkg::nes_btn_t [1:0] host_btn;  // decode -> merge
  nes_glue_pkg::nes_btn_t [1:0] pad_btn;   // merge -> joypad

  host_reg_decode host_reg_decode_i (
    .clk                 (clk),
    .sys_resetn          (sys_resetn),
    .i_host_wr           (i_host_wr),
    .o_loader_byte       (o_loader_byte),
    .o_loader_byte_valid (o_loader_byte_valid),
    .o_loader_reset      (o_loader_reset),
    .o_host_btn          (host_btn)
  );

  pad_merge #(
    .AUTOFIRE_PERIOD (AUTOFIRE_PERIOD)
  ) pad_merge_i (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .i_ds2      (i_ds2),
    .i_aux_btn  (i_aux_btn),
    .i_host_btn (host_btn),
    .o_pad_btn  (pad_btn)
  );

  joypad_port joypad_port_i (
    .clk          (clk),
    .sys_resetn   (sys_resetn),
    .i_pad_btn    (pad_btn),
    .i_joy_strobe (i_joy_strobe),
    .i_joy_clk    (i_joy_clk),
    .o_joy_data   (o_joy_data)
  );

  mem_scheduler mem_scheduler_i (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .i_loader_done (i_loader_done),
    .i_nes_req     (i_nes_req),
    .i_loader_wr   (i_loader_wr),
    .o_run_mem     (o_run_mem),
    .o_run_nes     (o_run_nes),
    .o_mem_cmd     (o_mem_cmd)
  );

endmodule

// File: verif/tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source. 100 ns clock, synchronous active low
// reset held for 16 rising edges and released just after an edge.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic sys_resetn
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    sys_resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #10 sys_resetn = 1'b1;  // same offset as other inputs
  end

endmodule

// File: verif/tb_nes_glue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the NES glue top. Drives host writes, pads and joypad clocks,
// memory requests; a clocked monitor checks slots, memory command and loader
// outputs every cycle against a reference model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_nes_glue;

  localparam int AF_PERIOD = 8;
  localparam int CLK_NS    = 100;
  // cycles per test
  localparam int RESET_CYC  = 20;
  localparam int BUDGET_CYC = RESET_CYC + 40 + 30 + 150 + 60 + 50 + 35;
  localparam int TIMEOUT_NS = BUDGET_CYC * CLK_NS * 3 / 2;  // 50 percent margin

  logic                         clk;
  logic                         sys_resetn;
  nes_glue_pkg::host_wr_t       host_wr;
  logic [7:0]                   loader_byte;
  logic                         loader_byte_valid;
  logic                         loader_reset;
  nes_glue_pkg::ds2_rx_t [1:0]  ds2;
  nes_glue_pkg::nes_btn_t [1:0] aux_btn;
  logic                         joy_strobe;
  logic [1:0]                   joy_clk;
  logic [1:0]                   joy_data;
  logic                         loader_done;
  nes_glue_pkg::nes_mem_req_t   nes_req;
  nes_glue_pkg::loader_wr_t     loader_wr;
  logic                         run_mem;
  logic                         run_nes;
  nes_glue_pkg::mem_cmd_t       mem_cmd;

  logic [31:0] lcg_state;
  int          errors;
  int          errors_at_start;
  int          tests_passed;
  int          tests_failed;
  int          tb_phase;      // reference phase, 0 is the memory slot
  logic        exp_ld_valid;
  logic [7:0]  exp_ld_byte;
  logic        exp_ld_reset;

  tb_clock_gen clock_gen_i (
    .clk        (clk),
    .sys_resetn (sys_resetn)
  );

  nes_glue_top #(
    .AUTOFIRE_PERIOD (AF_PERIOD)
  ) dut_i (
    .clk                 (clk),
    .sys_resetn          (sys_resetn),
    .i_host_wr           (host_wr),
    .o_loader_byte       (loader_byte),
    .o_loader_byte_valid (loader_byte_valid),
    .o_loader_reset      (loader_reset),
    .i_ds2               (ds2),
    .i_aux_btn           (aux_btn),
    .i_joy_strobe        (joy_strobe),
    .i_joy_clk           (joy_clk),
    .o_joy_data          (joy_data),
    .i_loader_done       (loader_done),
    .i_nes_req           (nes_req),
    .i_loader_wr         (loader_wr),
    .o_run_mem           (run_mem),
    .o_run_nes           (run_nes),
    .o_mem_cmd           (mem_cmd)
  );

  function automatic logic [31:0] rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // NES byte for one pad from the Dualshock bit table, square and triangle ignored
  function automatic logic [7:0] ds2_to_nes(input nes_glue_pkg::ds2_rx_t rx);
    logic [7:0] p0;
    logic [7:0] p1;
    p0 = ~rx.rx0;
    p1 = ~rx.rx1;
    // right left down up start select b(cross) a(circle)
    return {p0[5], p0[7], p0[6], p0[4], p0[3], p0[0], p1[6], p1[5]};
  endfunction

  function automatic nes_glue_pkg::mem_cmd_t expected_cmd(
    input nes_glue_pkg::nes_mem_req_t req,
    input nes_glue_pkg::loader_wr_t   lw,
    input logic                       slot
  );
    nes_glue_pkg::mem_cmd_t cmd;
    logic                   idle;
    cmd  = '0;
    idle = !(req.read_cpu || req.read_ppu || req.write);
    if (lw.write) begin
      cmd.write = 1'b1;
      cmd.addr  = lw.addr;
      cmd.data  = lw.data;
    end else begin
      cmd.read_a  = req.read_cpu && slot;
      cmd.read_b  = req.read_ppu && slot;
      cmd.write   = req.write && slot;
      cmd.refresh = (slot && idle) || lw.refresh;
      cmd.addr    = req.addr;
      cmd.data    = req.data;
    end
    return cmd;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("mismatch at %0t ns: %s got 'h%0h expected 'h%0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #10;
  endtask

  task automatic host_write(input logic [7:0] addr, input logic [7:0] data);
    host_wr.valid = 1'b1;
    host_wr.addr  = addr;
    host_wr.data  = data;
    tick(1);
    host_wr = '0;
  endtask

  // strobe, then eight falling joypad clocks on both ports
  task automatic read_pads(output logic [7:0] got0, output logic [7:0] got1);
    joy_strobe = 1'b1;
    tick(1);
    joy_strobe = 1'b0;
    for (int i = 0; i < 8; i++) begin
      got0[i] = joy_data[0];
      got1[i] = joy_data[1];
      joy_clk = 2'b11;
      tick(1);
      joy_clk = 2'b00;
      tick(1);
    end
    assert (joy_data == 2'b00) else report_mismatch("o_joy_data", joy_data, 2'b00);
  endtask

  task automatic read_b(output logic [1:0] b);
    joy_strobe = 1'b1;
    tick(1);
    joy_strobe = 1'b0;
    joy_clk    = 2'b11;
    tick(1);
    joy_clk = 2'b00;
    tick(1);
    b = joy_data;  // a shifted out, b at bit 0
  endtask

  task automatic drive_nes_req(input logic idle);
    logic [31:0] r;
    r = rand_word();
    nes_req.read_cpu = r[0] && !idle;
    nes_req.read_ppu = r[1] && !idle;
    nes_req.write    = r[2] && !idle;
    nes_req.addr     = r[31:10];
    nes_req.data     = r[9:2];
  endtask

  task automatic begin_test();
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == errors_at_start) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errors_at_start);
    end
  endtask

  // reference for phase and loader registers
  always @(posedge clk) begin
    if (!sys_resetn) begin
      tb_phase     <= 0;
      exp_ld_valid <= 1'b0;
      exp_ld_byte  <= '0;
      exp_ld_reset <= 1'b0;
    end else begin
      tb_phase     <= (tb_phase == 4) ? 0 : tb_phase + 1;
      exp_ld_valid <= host_wr.valid && host_wr.addr == nes_glue_pkg::REG_LOADER_DATA;
      if (host_wr.valid && host_wr.addr == nes_glue_pkg::REG_LOADER_DATA) begin
        exp_ld_byte <= host_wr.data;
      end
      if (host_wr.valid && host_wr.addr == nes_glue_pkg::REG_LOADER_CONF) begin
        exp_ld_reset <= host_wr.data[0];
      end
    end
  end

  // checks at mid cycle, inputs and registers settled
  always @(negedge clk) begin : monitor
    logic                   exp_mem;
    logic                   exp_nes;
    nes_glue_pkg::mem_cmd_t exp_cmd;
    if (sys_resetn) begin
      exp_mem = (tb_phase == 0) && loader_done;
      exp_nes = (tb_phase == 4) && loader_done;
      exp_cmd = expected_cmd(nes_req, loader_wr, exp_mem);
      assert (run_mem == exp_mem) else report_mismatch("o_run_mem", run_mem, exp_mem);
      assert (run_nes == exp_nes) else report_mismatch("o_run_nes", run_nes, exp_nes);
      assert (mem_cmd == exp_cmd) else report_mismatch("o_mem_cmd", mem_cmd, exp_cmd);
      assert (loader_byte_valid == exp_ld_valid)
        else report_mismatch("o_loader_byte_valid", loader_byte_valid, exp_ld_valid);
      assert (!exp_ld_valid || loader_byte == exp_ld_byte)
        else report_mismatch("o_loader_byte", loader_byte, exp_ld_byte);
      assert (loader_reset == exp_ld_reset)
        else report_mismatch("o_loader_reset", loader_reset, exp_ld_reset);
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    logic [7:0]  exp0;
    logic [7:0]  exp1;
    logic [7:0]  got0;
    logic [7:0]  got1;
    logic [1:0]  b;
    logic [1:0]  seen0;
    logic [1:0]  seen1;
    lcg_state    = 32'h7b5f_de07;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    host_wr      = '0;
    ds2          = '1;  // all released
    aux_btn      = '0;
    joy_strobe   = 1'b0;
    joy_clk      = 2'b00;
    loader_done  = 1'b0;
    nes_req      = '0;
    loader_wr    = '0;
    @(posedge sys_resetn);
    tick(2);

    begin_test();
    r    = rand_word();
    exp0 = r[7:0];
    exp1 = r[15:8];
    host_write(nes_glue_pkg::REG_BTN_P1, exp0);
    host_write(nes_glue_pkg::REG_BTN_P2, exp1);
    tick(2);
    read_pads(got0, got1);
    assert (got0 == exp0) else report_mismatch("port 0 byte", got0, exp0);
    assert (got1 == exp1) else report_mismatch("port 1 byte", got1, exp1);
    r = rand_word();
    assert (loader_reset == 1'b0) else report_mismatch("o_loader_reset", loader_reset, 0);
    host_write(nes_glue_pkg::REG_LOADER_CONF, r[7:0] | 8'h01);
    assert (loader_reset == 1'b1) else report_mismatch("o_loader_reset", loader_reset, 1);
    host_write(nes_glue_pkg::REG_LOADER_CONF, 8'h00);
    host_write(nes_glue_pkg::REG_BTN_P1, 8'h00);
    host_write(nes_glue_pkg::REG_BTN_P2, 8'h00);
    end_test("1 host register decode");

    begin_test();
    for (int i = 0; i < 16; i++) begin
      r             = rand_word();
      host_wr.valid = r[0] | r[1];
      // data address, low range, or a neighbour of it
      host_wr.addr  = r[2] ? nes_glue_pkg::REG_LOADER_DATA
                    : (r[3] ? {3'b000, r[12:8]} : 8'h36 + {r[8], 1'b0});
      host_wr.data  = r[23:16];
      tick(1);
    end
    host_wr = '0;
    tick(2);
    end_test("2 loader byte stream");

    begin_test();
    for (int i = 0; i < 6; i++) begin
      for (int p = 0; p < 2; p++) begin
        r          = rand_word();
        ds2[p].rx0 = r[7:0];
        ds2[p].rx1 = r[15:8] | 8'h90;  // square, triangle released
        aux_btn[p] = r[31] ? r[23:16] : 8'h00;
      end
      exp0 = ds2_to_nes(ds2[0]) | aux_btn[0];
      exp1 = ds2_to_nes(ds2[1]) | aux_btn[1];
      tick(2);
      read_pads(got0, got1);
      assert (got0 == exp0) else report_mismatch("port 0 byte", got0, exp0);
      assert (got1 == exp1) else report_mismatch("port 1 byte", got1, exp1);
    end
    ds2     = '1;
    aux_btn = '0;
    end_test("3 dualshock mapping");

    begin_test();
    ds2[0].rx1[7] = 1'b0;  // square held on both pads
    ds2[1].rx1[7] = 1'b0;
    seen0 = '0;
    seen1 = '0;
    tick(2);  // old pad byte leaves pad_btn
    // reads end while the autofire output is still high
    for (int i = 0; i < AF_PERIOD / 2; i++) begin
      read_b(b);
      seen0[b[0]] = 1'b1;
      seen1[b[1]] = 1'b1;
    end
    assert (seen0 == 2'b11) else begin
      $display("port 0 b bit did not toggle while square was held");
      errors++;
    end
    assert (seen1 == 2'b11) else begin
      $display("port 1 b bit did not toggle while square was held");
      errors++;
    end
    ds2 = '1;
    ds2[0].rx1[6] = 1'b0;  // cross on pad 0 only
    tick(2);
    for (int i = 0; i < 3; i++) begin
      read_b(b);
      assert (b == 2'b01) else report_mismatch("b bits after release", b, 2'b01);
    end
    ds2 = '1;
    tick(2);
    for (int i = 0; i < 3; i++) begin
      read_b(b);
      assert (b == 2'b00) else report_mismatch("b bits after release", b, 2'b00);
    end
    end_test("4 autofire");

    begin_test();
    for (int i = 0; i < 10; i++) begin
      drive_nes_req(i % 3 == 0);
      tick(1);
    end
    loader_done = 1'b1;
    for (int i = 0; i < 30; i++) begin
      drive_nes_req(i % 3 == 0);  // idle cycles fall into memory slots too
      tick(1);
    end
    nes_req = '0;
    tick(2);
    end_test("5 phase slots");

    begin_test();
    for (int i = 0; i < 25; i++) begin
      drive_nes_req(1'b0);
      r                 = rand_word();
      loader_wr.write   = r[0];
      loader_wr.refresh = r[1];
      loader_wr.addr    = r[31:10];
      loader_wr.data    = r[9:2];
      tick(1);
    end
    loader_wr = '0;
    nes_req   = '0;
    tick(2);
    end_test("6 loader priority");

    $display("tests done: %0d passed, %0d failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout: tests did not finish within %0d ns", TIMEOUT_NS);
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: build.f
common/nes_glue_pkg.sv
source/host_reg_decode.sv
source/pad_merge.sv
source/joypad_port.sv
mem/mem_scheduler.sv
source/nes_glue_top.sv
verif/tb_clock_gen.sv
verif/tb_nes_glue.sv

// File: Bender.yml
package:
  name: nes_glue

sources:
  - common/nes_glue_pkg.sv
  - source/host_reg_decode.sv
  - source/pad_merge.sv
  - source/joypad_port.sv
  - mem/mem_scheduler.sv
  - source/nes_glue_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_nes_glue.sv
